/* source/itof_pkg.sv */
/*
 * Shared types and format constants for the integer to single-precision
 * float converter. Modules import it inside their bodies and use scoped
 * names on their ports.
 */

package itof_pkg;

        // Integer operand width
        localparam int int_width = 32;

        // IEEE 754 single-precision field widths
        localparam int exp_width = 8;
        localparam int frac_width = 23;

        // Single-precision exponent bias
        localparam int exp_bias = 127;

        // Operand interpretation
        typedef enum logic [0:0] {
                op_unsigned = 1'b0,
                op_signed = 1'b1
        } itof_op_e;

        // Conversion request, 33 bits
        typedef struct packed {
                itof_op_e op;
                logic [int_width-1:0] operand;
        } itof_req_t;

        // Sign and magnitude from the operand stage, 34 bits
        typedef struct packed {
                logic sign;
                logic [int_width-1:0] magnitude;
                logic zero;
        } itof_mag_t;

        // Normalized value ahead of rounding, 37 bits
        // mant carries the hidden one in its top bit
        typedef struct packed {
                logic sign;
                logic [exp_width-1:0] exp;
                logic [frac_width:0] mant;
                logic guard;
                logic round;
                logic sticky;
                logic zero;
        } itof_norm_t;

        // Packed IEEE single, 32 bits
        typedef struct packed {
                logic sign;
                logic [exp_width-1:0] exp;
                logic [frac_width-1:0] frac;
        } float_t;

endpackage

/* source/itof_operand_stage.sv */
/*
 * Front stage of the converter. Takes a request strobe while idle,
 * forms sign and magnitude of the operand and holds busy until the
 * rounder reports the result through done.
 */

`timescale 1ns/1ps

module itof_operand_stage (
        input logic clk,
        input logic rst,
        input logic in_stb,
        input itof_pkg::itof_req_t req,
        input logic done,
        output logic busy,
        output logic mag_stb,
        output itof_pkg::itof_mag_t mag
);
        import itof_pkg::*;

        logic busy_q;
        logic accept;
        logic neg;
        logic [int_width-1:0] abs_val;

        // Done releases the converter in the cycle it arrives
        assign busy = busy_q & ~done;
        assign accept = in_stb & ~busy;

        // Only a signed request can be negative
        assign neg = (req.op == op_signed) & req.operand[int_width-1];

        // Two's complement negate, the most negative value maps to 2^31
        assign abs_val = neg ? (~req.operand + 1'b1) : req.operand;

        always_ff @(posedge clk) begin
                if (!rst) begin
                        busy_q <= 1'b0;
                        mag_stb <= 1'b0;
                end else begin
                        mag_stb <= accept;
                        // A new accept wins over the done of the previous one
                        if (accept) begin
                                busy_q <= 1'b1;
                        end else if (done) begin
                                busy_q <= 1'b0;
                        end
                end
        end

        // Payload is captured on acceptance
        always_ff @(posedge clk) begin
                if (accept) begin
                        mag.sign <= neg;
                        mag.magnitude <= abs_val;
                        mag.zero <= (req.operand == '0);
                end
        end

endmodule

/* source/itof_normalizer.sv */
/*
 * Normalizing stage. Shifts the magnitude left until its top bit is set,
 * counting the exponent down, then splits it into mantissa, guard, round
 * and sticky. COARSE_SHIFT sets the size of the fast step, 0 turns it off.
 */

`timescale 1ns/1ps

module itof_normalizer #(
        parameter int COARSE_SHIFT = 8
) (
        input logic clk,
        input logic rst,
        input logic mag_stb,
        input itof_pkg::itof_mag_t mag,
        output logic norm_stb,
        output itof_pkg::itof_norm_t norm
);
        import itof_pkg::*;

        typedef enum logic [1:0] {
                idle,
                shift,
                emit
        } norm_state_e;

        // Coarse window width, one bit when the coarse step is off
        localparam int coarse_w = (COARSE_SHIFT == 0) ? 1 : COARSE_SHIFT;

        // Bit positions below the mantissa
        localparam int guard_pos = int_width - frac_width - 2;
        localparam int round_pos = guard_pos - 1;

        norm_state_e state;
        logic [int_width-1:0] value;
        logic coarse_ok;
        logic [4:0] shift_amt;
        logic lead_one;

        assign lead_one = value[int_width-1];

        // Take the big step only when the whole window is zero
        assign coarse_ok = (COARSE_SHIFT != 0) &&
                           (value[int_width-1 -: coarse_w] == '0);
        assign shift_amt = coarse_ok ? 5'(coarse_w) : 5'd1;

        // Result is valid for the single cycle spent in emit
        assign norm_stb = (state == emit);

        always_ff @(posedge clk) begin
                if (!rst) begin
                        state <= idle;
                end else begin
                        case (state)
                                idle: begin
                                        if (mag_stb) begin
                                                // Zero has nothing to normalize
                                                if (mag.zero) begin
                                                        state <= emit;
                                                end else begin
                                                        state <= shift;
                                                end
                                        end
                                end
                                shift: begin
                                        if (lead_one) begin
                                                state <= emit;
                                        end
                                end
                                emit: begin
                                        state <= idle;
                                end
                                default: begin
                                        state <= idle;
                                end
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                case (state)
                        idle: begin
                                if (mag_stb) begin
                                        value <= mag.magnitude;
                                        norm.sign <= mag.sign;
                                        norm.zero <= mag.zero;
                                        // Top bit of the word has weight 2^31
                                        norm.exp <= exp_width'(int_width - 1);
                                        norm.mant <= '0;
                                        norm.guard <= 1'b0;
                                        norm.round <= 1'b0;
                                        norm.sticky <= 1'b0;
                                end
                        end
                        shift: begin
                                if (lead_one) begin
                                        norm.mant <= value[int_width-1 -: frac_width+1];
                                        norm.guard <= value[guard_pos];
                                        norm.round <= value[round_pos];
                                        norm.sticky <= |value[round_pos-1:0];
                                end else begin
                                        value <= value << shift_amt;
                                        norm.exp <= norm.exp - exp_width'(shift_amt);
                                end
                        end
                        default: begin
                                // emit holds the result for the rounder
                        end
                endcase
        end

endmodule

/* source/itof_rounder.sv */
/*
 * Output stage. Rounds the normalized value to nearest, ties to even,
 * adds the exponent bias and registers the packed float together with
 * a one-cycle out_stb. The result is held until the next conversion.
 */

`timescale 1ns/1ps

module itof_rounder (
        input logic clk,
        input logic rst,
        input logic norm_stb,
        input itof_pkg::itof_norm_t norm,
        output logic out_stb,
        output itof_pkg::float_t result
);
        import itof_pkg::*;

        logic round_up;
        logic carry;
        logic [frac_width+1:0] mant_sum;
        logic [exp_width-1:0] exp_biased;

        // Round up above half, or at exactly half when the mantissa is odd
        assign round_up = norm.guard & (norm.round | norm.sticky | norm.mant[0]);

        assign mant_sum = {1'b0, norm.mant} + {{(frac_width+1){1'b0}}, round_up};

        // All-ones mantissa overflows into the next binade
        assign carry = mant_sum[frac_width+1];

        assign exp_biased = norm.exp + exp_width'(exp_bias) +
                            {{(exp_width-1){1'b0}}, carry};

        always_ff @(posedge clk) begin
                if (!rst) begin
                        out_stb <= 1'b0;
                        result <= '0;
                end else begin
                        out_stb <= norm_stb;
                        if (norm_stb) begin
                                if (norm.zero) begin
                                        // Both opcodes give +0.0
                                        result <= '0;
                                end else begin
                                        result.sign <= norm.sign;
                                        result.exp <= exp_biased;
                                        // Fraction bits are zero after a carry
                                        result.frac <= mant_sum[frac_width-1:0];
                                end
                        end
                end
        end

endmodule

/* source/itof_converter.sv */
/*
 * Top level of the integer to float converter. Chains the operand stage,
 * the normalizer and the rounder, one conversion at a time. The source
 * may strobe a request whenever busy is low.
 */

`timescale 1ns/1ps

module itof_converter #(
        parameter int COARSE_SHIFT = 8
) (
        input logic clk,
        input logic rst,
        input logic in_stb,
        input itof_pkg::itof_req_t req,
        output logic busy,
        output logic out_stb,
        output itof_pkg::float_t result
);
        import itof_pkg::*;

        logic mag_stb;
        itof_mag_t mag;
        logic norm_stb;
        itof_norm_t norm;

        // out_stb doubles as the done signal that frees the front stage
        itof_operand_stage operand_i (
                .clk(clk),
                .rst(rst),
                .in_stb(in_stb),
                .req(req),
                .done(out_stb),
                .busy(busy),
                .mag_stb(mag_stb),
                .mag(mag)
        );

        itof_normalizer #(
                .COARSE_SHIFT(COARSE_SHIFT)
        ) normalizer_i (
                .clk(clk),
                .rst(rst),
                .mag_stb(mag_stb),
                .mag(mag),
                .norm_stb(norm_stb),
                .norm(norm)
        );

        itof_rounder rounder_i (
                .clk(clk),
                .rst(rst),
                .norm_stb(norm_stb),
                .norm(norm),
                .out_stb(out_stb),
                .result(result)
        );

endmodule

/* verification/itof_assertions.sv */
/*
 * Protocol checks on the converter outputs, bound to the top level.
 * Covers the one-cycle out_stb, its relation to busy and reset values.
 */

`timescale 1ns/1ps

module itof_assertions (
        input logic clk,
        input logic rst,
        input logic busy,
        input logic out_stb,
        input itof_pkg::float_t result
);

        out_stb_one_cycle: assert property (@(posedge clk) disable iff (!rst)
                out_stb |=> !out_stb)
                else $error("out_stb stayed high for more than one cycle");

        // A result only comes out of a running conversion
        out_stb_after_busy: assert property (@(posedge clk) disable iff (!rst)
                $rose(out_stb) |-> $past(busy))
                else $error("out_stb rose while busy was low");

        busy_falls_on_done: assert property (@(posedge clk) disable iff (!rst)
                $fell(busy) |-> out_stb)
                else $error("busy fell without out_stb");

        // Checked from the second reset cycle, once registers have been cleared
        outputs_in_reset: assert property (@(posedge clk)
                (!rst && $past(!rst)) |-> (!busy && !out_stb && result == '0))
                else $error("outputs not cleared during reset");

endmodule

/* verification/itof_tb.sv */
/*
 * Testbench for the integer to float converter. Drives random and corner
 * operands under both opcodes from an LFSR, compares every result with a
 * reference model and exercises the strobe and busy protocol.
 */

`timescale 1ns/1ps

module itof_tb;
        import itof_pkg::*;

        localparam int clk_period = 40;
        localparam int reset_cycles = 16;
        localparam int num_random = 300;
        localparam int num_corner = 14;
        localparam int num_decoy = 20;
        localparam int num_tests = 2 * num_random + num_corner + num_decoy;
        localparam int timeout_ns = num_tests * 40 * clk_period;

        // Longest path is 1 + 33 + 1 cycles, with some margin
        localparam int max_wait = 40;

        logic clk = 1'b0;
        logic rst;
        logic in_stb;
        itof_req_t req;
        logic busy;
        logic out_stb;
        float_t result;

        logic [31:0] lfsr_state = 32'd21;

        itof_converter #(
                .COARSE_SHIFT(8)
        ) dut_i (
                .clk(clk),
                .rst(rst),
                .in_stb(in_stb),
                .req(req),
                .busy(busy),
                .out_stb(out_stb),
                .result(result)
        );

        // The testbench holds a single converter, so a module bind reaches dut_i
        bind itof_converter itof_assertions assertions_i (
                .clk(clk),
                .rst(rst),
                .busy(busy),
                .out_stb(out_stb),
                .result(result)
        );

        always #(clk_period / 2) clk = ~clk;

        // Galois LFSR, x^32 + x^22 + x^2 + x + 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] state);
                logic [31:0] next;
                next = state >> 1;
                if (state[0]) begin
                        next = next ^ 32'h8020_0003;
                end
                return next;
        endfunction

        // One LFSR step per bit taken
        task automatic draw_bits(input int count, output logic [31:0] bits);
                int i;
                bits = '0;
                for (i = 0; i < count; i++) begin
                        lfsr_state = lfsr_next(lfsr_state);
                        bits = {bits[30:0], lfsr_state[0]};
                end
        endtask

        // Short operands are favoured so that small exponents show up too
        task automatic random_operand(input itof_op_e op, output logic [31:0] operand);
                logic [31:0] len;
                logic [31:0] raw;
                logic [31:0] neg;
                draw_bits(5, len);
                draw_bits(32, raw);
                operand = raw & (32'hffff_ffff >> (31 - len[4:0]));
                if (op == op_signed) begin
                        draw_bits(1, neg);
                        if (neg[0]) begin
                                operand = 32'd0 - operand;
                        end
                end
        endtask

        // Reference conversion, bits are read by position from the leading one
        function automatic float_t expected_float(input itof_op_e op,
                                                  input logic [31:0] operand);
                float_t f;
                logic negative;
                logic [31:0] mag;
                logic [23:0] mant;
                logic guard;
                logic round_bit;
                logic sticky;
                logic round_up;
                logic [24:0] sum;
                int lead;
                int e;
                int i;
                f = '0;
                negative = (op == op_signed) && operand[31];
                mag = negative ? (32'd0 - operand) : operand;
                if (mag == 32'd0) begin
                        return f;
                end
                lead = 0;
                for (i = 0; i < 32; i++) begin
                        if (mag[i]) begin
                                lead = i;
                        end
                end
                mant = '0;
                guard = 1'b0;
                round_bit = 1'b0;
                sticky = 1'b0;
                for (i = 0; i < 24; i++) begin
                        if (lead - i >= 0) begin
                                mant[23 - i] = mag[lead - i];
                        end
                end
                if (lead - 24 >= 0) begin
                        guard = mag[lead - 24];
                end
                if (lead - 25 >= 0) begin
                        round_bit = mag[lead - 25];
                end
                for (i = 0; i < lead - 25; i++) begin
                        sticky = sticky | mag[i];
                end
                // Nearest even: above half, or half with an odd mantissa
                round_up = guard & (round_bit | sticky | mant[0]);
                sum = {1'b0, mant} + {24'd0, round_up};
                e = lead;
                if (sum[24]) begin
                        e = e + 1;
                        sum = sum >> 1;
                end
                f.sign = negative;
                f.exp = 8'(e + exp_bias);
                f.frac = sum[22:0];
                return f;
        endfunction

        task automatic check_value(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
                if (expected !== actual) begin
                        $display("Error: %s expected %h actual %h", name, expected, actual);
                        $display("tests failed");
                        $fatal(1);
                end
        endtask

        task automatic fail_with(input string what);
                $display("Error: %s", what);
                $display("tests failed");
                $fatal(1);
        endtask

        // Inputs change and outputs are read 2 ns after the rising edge
        task automatic tick();
                @(posedge clk);
                #2;
        endtask

        task automatic check_idle_outputs(input string name);
                check_value({name, " busy"}, 32'd0, {31'd0, busy});
                check_value({name, " out_stb"}, 32'd0, {31'd0, out_stb});
                check_value({name, " result"}, 32'd0, result);
        endtask

        // One request from strobe to result, optionally with ignored strobes
        task automatic run_conversion(input string name, input itof_op_e op,
                                      input logic [31:0] operand, input bit decoys);
                float_t expected;
                float_t held;
                logic [31:0] bits;
                int cycles;
                int strobes;
                int n;
                expected = expected_float(op, operand);
                held = result;
                check_value({name, " busy before request"}, 32'd0, {31'd0, busy});
                in_stb = 1'b1;
                req.op = op;
                req.operand = operand;
                tick();
                in_stb = 1'b0;
                check_value({name, " busy after accept"}, 32'd1, {31'd0, busy});
                check_value({name, " out_stb after accept"}, 32'd0, {31'd0, out_stb});
                cycles = 0;
                while (!out_stb) begin
                        check_value({name, " result held"}, held, result);
                        if (cycles == max_wait) begin
                                fail_with($sformatf("no out_stb within %0d cycles for %s",
                                                    max_wait, name));
                        end
                        if (decoys) begin
                                // These land while busy is high and must be dropped
                                draw_bits(1, bits);
                                in_stb = bits[0];
                                draw_bits(32, bits);
                                req.op = itof_op_e'(bits[31]);
                                req.operand = bits;
                        end
                        tick();
                        in_stb = 1'b0;
                        cycles++;
                end
                check_value({name, " busy at out_stb"}, 32'd0, {31'd0, busy});
                check_value(name, expected, result);
                if (decoys) begin
                        strobes = 1;
                        for (n = 0; n < 3; n++) begin
                                tick();
                                if (out_stb) begin
                                        strobes++;
                                end
                                check_value({name, " busy after done"}, 32'd0, {31'd0, busy});
                                check_value({name, " result after done"}, expected, result);
                        end
                        check_value({name, " out_stb count"}, 32'd1, strobes);
                end
        endtask

        initial begin : watchdog
                #(timeout_ns);
                fail_with($sformatf("run timed out after %0d ns", timeout_ns));
        end

        initial begin : main
                logic [31:0] corners [7];
                logic [31:0] operand;
                logic [31:0] bits;
                int i;
                int k;
                rst = 1'b0;
                in_stb = 1'b0;
                req = '0;
                corners = '{32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff, 32'h8000_0000,
                            32'hffff_ffff, 32'h0100_0001, 32'h0100_0003};

                for (i = 0; i < reset_cycles; i++) begin
                        tick();
                        check_idle_outputs("during reset");
                end
                rst = 1'b1;
                for (i = 0; i < 2; i++) begin
                        tick();
                        check_idle_outputs("after reset");
                end

                // Back to back requests, each issued in the cycle busy falls
                for (i = 0; i < num_random; i++) begin
                        random_operand(op_unsigned, operand);
                        run_conversion($sformatf("unsigned %0d", i), op_unsigned, operand, 1'b0);
                end
                for (i = 0; i < num_random; i++) begin
                        random_operand(op_signed, operand);
                        run_conversion($sformatf("signed %0d", i), op_signed, operand, 1'b0);
                end

                for (k = 0; k < 7; k++) begin
                        run_conversion($sformatf("corner unsigned %h", corners[k]),
                                       op_unsigned, corners[k], 1'b0);
                        run_conversion($sformatf("corner signed %h", corners[k]),
                                       op_signed, corners[k], 1'b0);
                end

                for (i = 0; i < num_decoy; i++) begin
                        draw_bits(1, bits);
                        random_operand(itof_op_e'(bits[0]), operand);
                        run_conversion($sformatf("extra strobes %0d", i), itof_op_e'(bits[0]),
                                       operand, 1'b1);
                end

                $display("all tests passed");
                $finish;
        end

endmodule

/* verilog.f */
source/itof_pkg.sv
source/itof_operand_stage.sv
source/itof_normalizer.sv
source/itof_rounder.sv
source/itof_converter.sv
verification/itof_assertions.sv
verification/itof_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the converter testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal --top-module itof_tb -f verilog.f -o itof_sim
if [ $? -ne 0 ]; then
    echo "run_sim: build failed"
    exit 1
fi

output=$(./obj_dir/itof_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "all tests passed"; then
    echo "run_sim: PASS"
    exit 0
fi

echo "run_sim: pass message not found in output"
exit 1
